//--- Makefile
# Verilator build and run for the I2S capture block

VERILATOR ?= verilator
TOP       ?= fpga_ip_tb
FLIST     ?= fpga_ip_top.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD)

//--- fpga_ip_top.f
+incdir+include
hdl/wb_bus_pkg.sv
hdl/i2s_audio_pkg.sv
hdl/i2s_slave_rx.sv
hdl/i2s_sample_fifo.sv
hdl/wb_i2s_regs.sv
hdl/fpga_ip_top.sv
tb/fpga_ip_props.sv
tb/fpga_ip_checker.sv
tb/fpga_ip_tb.sv

//--- hdl/fpga_ip_top.sv
module fpga_ip_top (
    input  logic                wb_clk_i,       // bridge clock, >= 4x bit clock
    input  logic                arst_n_i,
    input  wb_bus_pkg::wb_req_t wb_req_i,
    output wb_bus_pkg::wb_rsp_t wb_rsp_o,
    input  logic                i2s_clk_i,
    input  logic                i2s_ws_i,
    input  logic                i2s_din_i,
    output logic                i2s_rx_intr_o
);
    import i2s_audio_pkg::*;

    logic         rx_en;
    logic         pair_valid;
    stereo_pair_t pair;
    logic         fifo_pop;
    stereo_pair_t fifo_head;
    fifo_level_t  fifo_level;
    logic         fifo_empty;
    logic         fifo_ovf;
    logic         ovf_clr;

    // ---------------------------------------------------------------------------
    // i2s receiver
    // ---------------------------------------------------------------------------
    i2s_slave_rx u_rx (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .rx_en_i      (rx_en),
        .i2s_clk_i    (i2s_clk_i),
        .i2s_ws_i     (i2s_ws_i),
        .i2s_din_i    (i2s_din_i),
        .pair_valid_o (pair_valid),   // no back-pressure
        .pair_o       (pair)
    );

    // pair buffer
    i2s_sample_fifo u_fifo (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (pair_valid),
        .push_data_i (pair),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_head),
        .level_o     (fifo_level),
        .empty_o     (fifo_empty),
        .full_o      (),              // level already shows it
        .overflow_o  (fifo_ovf),
        .ovf_clr_i   (ovf_clr)
    );

    // register block on the bridge
    wb_i2s_regs u_regs (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .fifo_data_i (fifo_head),
        .level_i     (fifo_level),
        .empty_i     (fifo_empty),
        .overflow_i  (fifo_ovf),
        .pop_o       (fifo_pop),
        .ovf_clr_o   (ovf_clr),
        .rx_en_o     (rx_en),
        .rx_intr_o   (i2s_rx_intr_o)
    );

endmodule

//--- hdl/i2s_audio_pkg.sv
`include "fpga_ip_config.svh"

package i2s_audio_pkg;

    // -----------------------------------------------------------------------
    // sample data
    // -----------------------------------------------------------------------
    typedef logic [`I2S_WORD_BITS-1:0] audio_word_t;   // one channel, two's compl

    // left in the upper half, same layout as the data register
    typedef struct packed {
        audio_word_t left;
        audio_word_t right;
    } stereo_pair_t;

    // occupancy 0..depth, needs one bit more than the pointers
    typedef logic [$clog2(`I2S_FIFO_DEPTH + 1)-1:0] fifo_level_t;

    // -----------------------------------------------------------------------
    // receiver fsm
    // -----------------------------------------------------------------------
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,    // waiting for ws to go low
        RX_LEFT  = 2'd1,    // ws low slot
        RX_RIGHT = 2'd2     // ws high slot
    } rx_state_e;

endpackage

//--- hdl/i2s_sample_fifo.sv
`include "fpga_ip_config.svh"

module i2s_sample_fifo (
    input  logic                        wb_clk_i,
    input  logic                        arst_n_i,
    input  logic                        push_i,
    input  i2s_audio_pkg::stereo_pair_t push_data_i,
    input  logic                        pop_i,
    output i2s_audio_pkg::stereo_pair_t pop_data_o,
    output i2s_audio_pkg::fifo_level_t  level_o,
    output logic                        empty_o,
    output logic                        full_o,
    output logic                        overflow_o,
    input  logic                        ovf_clr_i
);
    import i2s_audio_pkg::*;

    localparam int PTR_W = $clog2(`I2S_FIFO_DEPTH);

    stereo_pair_t   mem [`I2S_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    fifo_level_t    level_q;
    logic           ovf_q;
    logic           push_ok;
    logic           pop_ok;

    assign empty_o = (level_q == '0);
    assign full_o  = (level_q == fifo_level_t'(`I2S_FIFO_DEPTH));

    // a pop frees the slot in the same cycle, so full plus pop still accepts
    assign push_ok = push_i & (~full_o | pop_i);
    assign pop_ok  = pop_i & ~empty_o;

    always_ff @(posedge wb_clk_i) begin
        if (push_ok)
            mem[wr_ptr_q] <= push_data_i;
    end

    // ---------------------------------------------------------------------------
    // pointers, level, overflow
    // ---------------------------------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
            ovf_q    <= 1'b0;
        end else begin
            if (push_ok)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`I2S_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop_ok)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`I2S_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;    // both or neither
            endcase
            if (push_i && !push_ok)
                ovf_q <= 1'b1;                  // sticky, pair lost
            else if (ovf_clr_i)
                ovf_q <= 1'b0;
        end
    end

    assign pop_data_o = mem[rd_ptr_q];    // head, valid when not empty
    assign level_o    = level_q;
    assign overflow_o = ovf_q;

endmodule

//--- hdl/i2s_slave_rx.sv
`include "fpga_ip_config.svh"

module i2s_slave_rx (
    input  logic                        wb_clk_i,
    input  logic                        arst_n_i,
    input  logic                        rx_en_i,
    input  logic                        i2s_clk_i,     // async bit clock
    input  logic                        i2s_ws_i,      // async word select
    input  logic                        i2s_din_i,     // async serial data
    output logic                        pair_valid_o,
    output i2s_audio_pkg::stereo_pair_t pair_o
);
    import i2s_audio_pkg::*;

    localparam int CNT_W = $clog2(`I2S_WORD_BITS + 1);

    logic [2:0]       pin_s1;       // {clk, ws, din} first stage
    logic [2:0]       pin_s2;       // second stage, safe to use
    logic             clk_s3;       // edge register
    logic             bclk_rise;
    logic             ws_s;
    logic             din_s;
    logic             ws_q;         // ws seen at the previous rising edge
    logic             ws_edge;
    rx_state_e        state_q;
    logic [CNT_W-1:0] bit_cnt_q;    // bits kept in the current slot
    audio_word_t      shift_q;
    audio_word_t      word_next;
    audio_word_t      left_q;
    logic             word_done;
    logic             pair_valid_q;
    stereo_pair_t     pair_q;

    // ---------------------------------------------------------------------------
    // pin synchronizer and bit clock edge detect
    // ---------------------------------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pin_s1 <= '0;
            pin_s2 <= '0;
            clk_s3 <= 1'b0;
        end else begin
            pin_s1 <= {i2s_clk_i, i2s_ws_i, i2s_din_i};
            pin_s2 <= pin_s1;
            clk_s3 <= pin_s2[2];
        end
    end

    assign bclk_rise = pin_s2[2] & ~clk_s3;
    assign ws_s      = pin_s2[1];   // ws and din share the clock's delay
    assign din_s     = pin_s2[0];
    assign ws_edge   = ws_s ^ ws_q;

    // msb first, the newest bit enters at the bottom
    assign word_next = {shift_q[`I2S_WORD_BITS-2:0], din_s};

    // 16th bit of a slot, may arrive on the ws edge itself
    assign word_done = bclk_rise && (state_q != RX_IDLE)
                       && (bit_cnt_q == CNT_W'(`I2S_WORD_BITS - 1));

    // ---------------------------------------------------------------------------
    // slot tracking
    // ---------------------------------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ws_q      <= 1'b1;
            state_q   <= RX_IDLE;
            bit_cnt_q <= '0;
        end else if (!rx_en_i) begin
            ws_q      <= 1'b1;      // so a low ws after enable counts as a frame start
            state_q   <= RX_IDLE;
            bit_cnt_q <= '0;
        end else if (bclk_rise) begin
            ws_q <= ws_s;
            if (state_q != RX_IDLE && bit_cnt_q < CNT_W'(`I2S_WORD_BITS))
                bit_cnt_q <= bit_cnt_q + 1'b1;  // saturates, extra bits dropped
            if (ws_edge) begin
                // this bit closes the old slot, the msb comes on the next edge
                bit_cnt_q <= '0;
                if (state_q != RX_IDLE)
                    state_q <= ws_s ? RX_RIGHT : RX_LEFT;
                else if (!ws_s)
                    state_q <= RX_LEFT;     // first falling ws
            end
        end
    end

    // data path, no reset needed
    always_ff @(posedge wb_clk_i) begin
        if (bclk_rise)
            shift_q <= word_next;
        if (word_done && state_q == RX_LEFT)
            left_q <= word_next;
        if (word_done && state_q == RX_RIGHT) begin
            pair_q.left  <= left_q;
            pair_q.right <= word_next;
        end
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            pair_valid_q <= 1'b0;
        else
            pair_valid_q <= word_done && (state_q == RX_RIGHT) && rx_en_i;
    end

    assign pair_valid_o = pair_valid_q;
    assign pair_o       = pair_q;

endmodule

//--- hdl/wb_bus_pkg.sv
package wb_bus_pkg;

    // -----------------------------------------------------------------------
    // bridge side widths
    // -----------------------------------------------------------------------
    typedef logic [16:0] wb_addr_t;     // word address from the bridge
    typedef logic [31:0] wb_data_t;     // full word, no byte lanes here

    // master to slave
    typedef struct packed {
        logic     cyc;                  // cycle, acts as chip select
        logic     stb;                  // transfer strobe
        logic     we;                   // 1 = write
        wb_addr_t adr;
        wb_data_t wr_dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic     ack;                  // single cycle pulse per transfer
        wb_data_t rd_dat;               // valid with ack only
    } wb_rsp_t;

    // one request gets exactly one ack, the master drops stb after it
    // and may start the next access right away

endpackage

//--- hdl/wb_i2s_regs.sv
`include "fpga_ip_config.svh"

module wb_i2s_regs (
    input  logic                        wb_clk_i,
    input  logic                        arst_n_i,
    input  wb_bus_pkg::wb_req_t         wb_req_i,
    output wb_bus_pkg::wb_rsp_t         wb_rsp_o,
    input  i2s_audio_pkg::stereo_pair_t fifo_data_i,
    input  i2s_audio_pkg::fifo_level_t  level_i,
    input  logic                        empty_i,
    input  logic                        overflow_i,
    output logic                        pop_o,
    output logic                        ovf_clr_o,
    output logic                        rx_en_o,
    output logic                        rx_intr_o
);
    import wb_bus_pkg::*;

    // control bits
    localparam int CTRL_RX_EN  = 0;
    localparam int CTRL_IRQ_EN = 1;
    // status bit, write 1 clears
    localparam int STAT_OVF    = 5;

    logic       req_valid;      // new request, not yet acked
    logic       wr_req;
    logic       rd_req;
    logic       ack_q;
    wb_data_t   rd_mux;
    wb_data_t   rd_dat_q;
    logic [1:0] ctrl_q;
    logic       pop_q;
    logic       ovf_clr_q;
    logic       intr_q;

    assign req_valid = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr_req    = req_valid &  wb_req_i.we;
    assign rd_req    = req_valid & ~wb_req_i.we;

    // ---------------------------------------------------------------------------
    // read mux, sampled on the request cycle
    // ---------------------------------------------------------------------------
    always_comb begin
        case (wb_req_i.adr)
            `REG_CTRL:   rd_mux = wb_data_t'(ctrl_q);
            `REG_STATUS: rd_mux = wb_data_t'({overflow_i, empty_i, level_i});
            `REG_DATA:   rd_mux = empty_i ? '0 : wb_data_t'(fifo_data_i);
            `REG_ID:     rd_mux = wb_data_t'(`DEVICE_ID);
            default:     rd_mux = '0;       // unmapped
        endcase
    end

    // read data only needs to hold through the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (rd_req)
            rd_dat_q <= rd_mux;
    end

    // ---------------------------------------------------------------------------
    // ack, control, strobes, interrupt
    // ---------------------------------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q     <= 1'b0;
            ctrl_q    <= '0;
            pop_q     <= 1'b0;
            ovf_clr_q <= 1'b0;
            intr_q    <= 1'b0;
        end else begin
            ack_q <= req_valid;     // one cycle later, one cycle long

            // head captured above is popped on the ack cycle, empty reads skip it
            pop_q <= rd_req && (wb_req_i.adr == `REG_DATA) && !empty_i;

            ovf_clr_q <= wr_req && (wb_req_i.adr == `REG_STATUS)
                         && wb_req_i.wr_dat[STAT_OVF];

            if (wr_req && wb_req_i.adr == `REG_CTRL)
                ctrl_q <= wb_req_i.wr_dat[1:0];     // visible with the ack

            intr_q <= ctrl_q[CTRL_IRQ_EN] & ~empty_i;   // level style irq
        end
    end

    assign wb_rsp_o.ack    = ack_q;
    assign wb_rsp_o.rd_dat = rd_dat_q;

    assign pop_o     = pop_q;
    assign ovf_clr_o = ovf_clr_q;
    assign rx_en_o   = ctrl_q[CTRL_RX_EN];
    assign rx_intr_o = intr_q;

endmodule

//--- include/fpga_ip_config.svh
`ifndef FPGA_IP_CONFIG_SVH
`define FPGA_IP_CONFIG_SVH

// ---------------------------------------------------------------------------
// audio capture sizing
// ---------------------------------------------------------------------------
`define I2S_WORD_BITS   16          // bits per channel word
`define I2S_FIFO_DEPTH  8           // stereo pairs held before overflow

// ---------------------------------------------------------------------------
// register map, word addresses on the wishbone adr field
// ---------------------------------------------------------------------------
`define REG_CTRL        17'h0_0000  // rx enable, irq enable
`define REG_STATUS      17'h0_0001  // level, empty, overflow (w1c)
`define REG_DATA        17'h0_0002  // oldest pair, read pops
`define REG_ID          17'h0_0003  // device id, read only

// returned in the low 20 bits of REG_ID
`define DEVICE_ID       20'h1_2530

`endif

//--- tb/fpga_ip_checker.sv
module fpga_ip_checker (
    input logic wb_clk_i
);
    import wb_bus_pkg::*;

    int       err_cnt  = 0;
    int       chk_cnt  = 0;
    int       test_cnt = 0;
    int       test_err = 0;     // errors in the running test
    int       test_chk = 0;
    logic     armed    = 1'b0;  // a read is in flight with a posted value
    wb_data_t exp_dat  = '0;
    string    exp_name = "";

    // called by the master when it launches a read
    task automatic post_expect(input string name, input wb_data_t val);
        exp_name = name;
        exp_dat  = val;
        armed    = 1'b1;
    endtask

    task automatic note_fail(input string what);
        $display("%0t: %s", $time, what);
        err_cnt++;
        test_err++;
    endtask

    // ------------------------------------------------------------------------
    // read data compare, ack is stable at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge wb_clk_i) begin
        if (fpga_ip_tb.u_dut.wb_rsp_o.ack && armed) begin
            armed = 1'b0;
            chk_cnt++;
            test_chk++;
            if (fpga_ip_tb.u_dut.wb_rsp_o.rd_dat !== exp_dat) begin
                $display("error at %0t: wb_rsp_o.rd_dat (%s) got %h, expected %h",
                         $time, exp_name, fpga_ip_tb.u_dut.wb_rsp_o.rd_dat, exp_dat);
                err_cnt++;
                test_err++;
            end
        end
    end

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s: %0d reads checked, %0d errors",
                 test_cnt, name, test_chk, test_err);
        test_chk = 0;
        test_err = 0;
    endtask

    task automatic report();
        $display("summary: %0d tests, %0d reads checked, %0d errors",
                 test_cnt, chk_cnt, err_cnt);
    endtask

endmodule

//--- tb/fpga_ip_props.sv
module fpga_ip_props (
    input logic                wb_clk_i,
    input logic                arst_n_i,
    input wb_bus_pkg::wb_req_t wb_req_i,
    input wb_bus_pkg::wb_rsp_t wb_rsp_i,
    input logic                intr_i,
    input logic                irq_en_i
);
    int fail_cnt = 0;   // failed assertions so far

    // single cycle ack
    ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            fail_cnt++;
            $error("ack held longer than one cycle");
        end

    // ack answers a request seen one clock earlier
    ack_after_req: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else begin
            fail_cnt++;
            $error("ack without cyc and stb");
        end

    ack_in_reset: assert property (@(posedge wb_clk_i) !arst_n_i |-> !wb_rsp_i.ack)
        else begin
            fail_cnt++;
            $error("ack during reset");
        end

    // irq is registered, so enable is checked one cycle back
    intr_needs_en: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        intr_i |-> $past(irq_en_i))
        else begin
            fail_cnt++;
            $error("interrupt with interrupt enable clear");
        end

endmodule

//--- tb/fpga_ip_tb.sv
`include "fpga_ip_config.svh"

module fpga_ip_tb;
    import wb_bus_pkg::*;
    import i2s_audio_pkg::*;

    localparam int CLK_T       = 8;
    localparam int BIT_T       = 48;         // i2s bit clock period
    localparam int FRAME_BITS  = 33;         // frame start bit + 16 left + 16 right
    localparam int N_FRAMES    = 22;         // frames sent over all tests
    localparam int N_ACCESS    = 40;         // bus accesses, rounded up
    localparam int ACC_T       = 4 * CLK_T;
    localparam int SETTLE_CYC  = 12;         // pair_valid plus fifo push
    localparam int N_BURSTS    = 6;
    localparam int ACK_TIMEOUT = 16;
    localparam int RUN_T       = N_FRAMES * FRAME_BITS * BIT_T + N_ACCESS * ACC_T
                                 + N_BURSTS * SETTLE_CYC * CLK_T + 100 * CLK_T;
    localparam int LIMIT_T     = RUN_T * 3 / 2;

    logic         clk;
    logic         arst_n;
    wb_req_t      req;
    wb_rsp_t      rsp;
    logic         i2s_clk;
    logic         i2s_ws;
    logic         i2s_din;
    logic         intr;
    integer       seed;
    stereo_pair_t exp_q [$];    // pairs the fifo should hold, oldest first
    logic         exp_ovf;
    logic         rx_en_m;      // model copy of rx enable
    logic         seen;

    always #(CLK_T / 2) clk = ~clk;

    fpga_ip_top u_dut (
        .wb_clk_i      (clk),
        .arst_n_i      (arst_n),
        .wb_req_i      (req),
        .wb_rsp_o      (rsp),
        .i2s_clk_i     (i2s_clk),
        .i2s_ws_i      (i2s_ws),
        .i2s_din_i     (i2s_din),
        .i2s_rx_intr_o (intr)
    );

    fpga_ip_checker u_chk (.wb_clk_i(clk));

    bind fpga_ip_top fpga_ip_props u_props (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .wb_req_i (wb_req_i),
        .wb_rsp_i (wb_rsp_o),
        .intr_i   (i2s_rx_intr_o),
        .irq_en_i (u_regs.ctrl_q[1])
    );

    // {accepted, pair}: nothing kept while disabled or with 8 pairs waiting
    function automatic logic [32:0] expected_pair(input logic en, input int outstanding,
                                                  input audio_word_t l, input audio_word_t r);
        if (!en)
            return {1'b0, l, r};
        if (outstanding >= `I2S_FIFO_DEPTH)
            return {1'b0, l, r};
        return {1'b1, l, r};     // left high, right low
    endfunction

    function automatic wb_data_t status_exp();
        return {26'b0, exp_ovf, (exp_q.size() == 0), 4'(exp_q.size())};
    endfunction

    // ------------------------------------------------------------------------
    // i2s master side
    // ------------------------------------------------------------------------
    task automatic send_bit(input logic w, input logic d);
        i2s_ws  = w;                // changes with the falling bit clock
        i2s_din = d;
        repeat (BIT_T / CLK_T / 2) @(negedge clk);
        i2s_clk = 1'b1;
        repeat (BIT_T / CLK_T / 2) @(negedge clk);
        i2s_clk = 1'b0;
    endtask

    task automatic send_frames(input int n);
        audio_word_t l;
        audio_word_t r;
        logic [32:0] res;
        @(negedge clk);
        for (int k = 0; k < n; k++) begin
            l   = audio_word_t'($random(seed));
            r   = audio_word_t'($random(seed));
            res = expected_pair(rx_en_m, exp_q.size(), l, r);
            if (res[32])
                exp_q.push_back(res[31:0]);
            else if (rx_en_m)
                exp_ovf = 1'b1;
            send_bit(1'b0, 1'b0);                   // ws falls, closes last slot
            for (int i = 1; i <= 16; i++)
                send_bit(i == 16, l[16-i]);         // ws rises with the left lsb
            for (int i = 17; i <= 32; i++)
                send_bit(1'b1, r[32-i]);
        end
        repeat (SETTLE_CYC) @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // wishbone master
    // ------------------------------------------------------------------------
    task automatic bus_access(input logic we, input wb_addr_t a, input wb_data_t d,
                              input string name, input wb_data_t expect_dat);
        int n;
        n = 0;
        @(negedge clk);
        if (!we)
            u_chk.post_expect(name, expect_dat);
        req.cyc    = 1'b1;
        req.stb    = 1'b1;
        req.we     = we;
        req.adr    = a;
        req.wr_dat = d;
        @(negedge clk);
        while (!rsp.ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.ack)
            u_chk.note_fail($sformatf("no ack from address %h", a));
        req = '0;
    endtask

    task automatic wb_read(input wb_addr_t a, input string name, input wb_data_t expect_dat);
        bus_access(1'b0, a, '0, name, expect_dat);
    endtask

    task automatic wb_write(input wb_addr_t a, input wb_data_t d);
        bus_access(1'b1, a, d, "", '0);
        if (a == `REG_CTRL)
            rx_en_m = d[0];
        if (a == `REG_STATUS && d[5])
            exp_ovf = 1'b0;
    endtask

    task automatic read_data();
        wb_read(`REG_DATA, "data", (exp_q.size() != 0) ? wb_data_t'(exp_q.pop_front()) : '0);
    endtask

    task automatic wait_intr(input logic lvl, input int cycles, output logic found);
        found = 1'b0;
        for (int i = 0; i < cycles && !found; i++) begin
            @(negedge clk);
            if (intr == lvl)
                found = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        seed     = 32'h5252_a1ca;
        clk      = 1'b0;
        arst_n   = 1'b0;
        req      = '0;
        i2s_clk  = 1'b0;
        i2s_ws   = 1'b1;            // idle high, first low is a frame start
        i2s_din  = 1'b0;
        exp_ovf  = 1'b0;
        rx_en_m  = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        @(negedge clk);
        if (rsp.ack || intr)
            u_chk.note_fail("ack or interrupt high right after reset");
        wb_read(`REG_STATUS, "status", status_exp());
        wb_read(`REG_ID, "id", wb_data_t'(`DEVICE_ID));
        u_chk.end_test("reset state");

        wb_write(`REG_CTRL, 32'h1);
        send_frames(6);
        repeat (6) read_data();
        read_data();                // queue empty now, expects 0
        u_chk.end_test("capture and read back");

        wb_write(`REG_CTRL, 32'h0);
        send_frames(3);
        wb_read(`REG_STATUS, "status", status_exp());
        u_chk.end_test("receiver disabled");

        wb_write(`REG_CTRL, 32'h1);
        send_frames(11);
        wb_read(`REG_STATUS, "status", status_exp());
        repeat (8) read_data();
        wb_write(`REG_STATUS, 32'h20);
        wb_read(`REG_STATUS, "status", status_exp());
        u_chk.end_test("overflow");

        wb_write(`REG_CTRL, 32'h3);
        send_frames(1);
        wait_intr(1'b1, 20, seen);
        if (!seen)
            u_chk.note_fail("interrupt did not rise with a pair waiting");
        read_data();
        wait_intr(1'b0, 4, seen);
        if (!seen)
            u_chk.note_fail("interrupt stayed high after the fifo emptied");
        wb_write(`REG_CTRL, 32'h1);
        send_frames(1);
        wait_intr(1'b1, 10, seen);
        if (seen)
            u_chk.note_fail("interrupt rose with interrupt enable clear");
        read_data();
        u_chk.end_test("interrupt");

        u_chk.report();
        if (u_chk.err_cnt == 0 && u_dut.u_props.fail_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT_T);
        $display("timeout, run did not finish within %0d time units", LIMIT_T);
        $display("test failed");
        $finish;
    end

endmodule
